/* rtl/cic_pkg.sv */
package cic_pkg;

	// ----------------------------------------
	// datapath widths
	// ----------------------------------------
	localparam int IN_WIDTH = 16;
	localparam int OUT_WIDTH = 16;
	localparam int STAGES = 4;
	localparam int MAX_LOG2 = 5;

	// full bit growth for the largest R, no pruning
	localparam int ACC_WIDTH = IN_WIDTH + STAGES * MAX_LOG2;
	localparam int LOG2_WIDTH = 3;

	// ----------------------------------------
	// register map
	// ----------------------------------------
	localparam logic [7:0] CTRL_ADDR = 8'h00;
	localparam logic [7:0] COUNT_ADDR = 8'h04;

	// ----------------------------------------
	// sample and bus types
	// ----------------------------------------
	typedef struct packed {
		logic valid;
		logic signed [IN_WIDTH-1:0] data;
	} in_sample_t;

	typedef struct packed {
		logic valid;
		logic signed [ACC_WIDTH-1:0] data;
	} acc_sample_t;

	typedef struct packed {
		logic valid;
		logic signed [OUT_WIDTH-1:0] data;
	} out_sample_t;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [7:0] paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic pready;
		logic pslverr;
		logic [31:0] prdata;
	} apb_rsp_t;

endpackage

/* rtl/cic_apb_regs.sv */
module cic_apb_regs
	import cic_pkg::*;
(
	input  logic clock,
	input  logic reset,
	input  apb_req_t apb_req,
	output apb_rsp_t apb_rsp,
	input  logic out_valid,
	output logic enable,
	output logic [LOG2_WIDTH-1:0] log2_r,
	output logic clear
);

	logic access;
	logic ctrl_hit;
	logic count_hit;
	logic range_ok;
	logic ctrl_write;
	logic bad_write;
	logic bad_read;
	logic [31:0] out_count;

	// ----------------------------------------
	// access decode
	// ----------------------------------------
	assign access = apb_req.psel && apb_req.penable;
	assign ctrl_hit = (apb_req.paddr == CTRL_ADDR);
	assign count_hit = (apb_req.paddr == COUNT_ADDR);
	assign range_ok = (apb_req.pwdata[LOG2_WIDTH:1] <= LOG2_WIDTH'(MAX_LOG2));

	assign ctrl_write = access && apb_req.pwrite && ctrl_hit && range_ok;
	// count register is read-only, so only the control word takes writes
	assign bad_write = apb_req.pwrite && !(ctrl_hit && range_ok);
	assign bad_read = !apb_req.pwrite && !ctrl_hit && !count_hit;

	// ----------------------------------------
	// control register and output counter
	// ----------------------------------------
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			enable <= 1'b0;
			log2_r <= '0;
			clear <= 1'b0;
			out_count <= '0;
		end
		else
		begin
			// flush pulse follows the accepted write by one cycle
			clear <= ctrl_write;
			if (ctrl_write)
			begin
				{log2_r, enable} <= apb_req.pwdata[LOG2_WIDTH:0];
			end
			// strobes still in flight before the flush are not counted
			if (ctrl_write || clear)
				out_count <= '0;
			else if (out_valid)
				out_count <= out_count + 32'd1;
		end
	end

	// ----------------------------------------
	// response, zero wait states
	// ----------------------------------------
	assign apb_rsp.pready = 1'b1;
	assign apb_rsp.pslverr = access && (bad_write || bad_read);

	always_comb
	begin
		case (apb_req.paddr)
			CTRL_ADDR: apb_rsp.prdata = {{(31 - LOG2_WIDTH){1'b0}}, log2_r, enable};
			COUNT_ADDR: apb_rsp.prdata = out_count;
			default: apb_rsp.prdata = '0;
		endcase
	end

endmodule

/* rtl/cic_integrator_chain.sv */
module cic_integrator_chain
	import cic_pkg::*;
(
	input  logic clock,
	input  logic reset,
	input  logic clear,
	input  logic enable,
	input  in_sample_t sample_in,
	output acc_sample_t acc_out
);

	logic strobe;
	logic valid_q;
	logic signed [ACC_WIDTH-1:0] extended;
	logic signed [ACC_WIDTH-1:0] stage_in [STAGES];
	logic signed [ACC_WIDTH-1:0] integ [STAGES];

	// samples are dropped while the filter is disabled
	assign strobe = sample_in.valid && enable;

	assign extended = {{(ACC_WIDTH - IN_WIDTH){sample_in.data[IN_WIDTH-1]}}, sample_in.data};

	// ----------------------------------------
	// integrator stages
	// ----------------------------------------
	for (genvar i = 0; i < STAGES; i++)
	begin : g_stage
		if (i == 0)
		begin : g_first
			assign stage_in[i] = extended;
		end
		else
		begin : g_next
			// old value of the previous stage, one sample lag each
			assign stage_in[i] = integ[i-1];
		end

		// modular arithmetic, wraparound is harmless in a CIC
		always_ff @(posedge clock)
		begin
			if (reset || clear)
				integ[i] <= '0;
			else if (strobe)
				integ[i] <= integ[i] + stage_in[i];
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset || clear)
			valid_q <= 1'b0;
		else
			valid_q <= strobe;
	end

	assign acc_out = '{valid: valid_q, data: integ[STAGES-1]};

endmodule

/* rtl/cic_decimation_ctrl.sv */
module cic_decimation_ctrl
	import cic_pkg::*;
(
	input  logic clock,
	input  logic reset,
	input  logic clear,
	input  logic [LOG2_WIDTH-1:0] log2_r,
	input  acc_sample_t acc_in,
	output acc_sample_t acc_out
);

	logic [MAX_LOG2-1:0] sample_no;
	logic [MAX_LOG2-1:0] last_no;
	logic group_end;

	// R - 1 as a mask, all ones for R = 32
	assign last_no = ~({MAX_LOG2{1'b1}} << log2_r);
	assign group_end = (sample_no == last_no);

	// ----------------------------------------
	// group counter
	// ----------------------------------------
	always_ff @(posedge clock)
	begin
		if (reset || clear)
			sample_no <= '0;
		else if (acc_in.valid)
		begin
			if (group_end)
				sample_no <= '0;
			else
				sample_no <= sample_no + 1'b1;
		end
	end

	// keep one sample per group
	always_ff @(posedge clock)
	begin
		if (reset || clear)
			acc_out.valid <= 1'b0;
		else
			acc_out.valid <= acc_in.valid && group_end;
	end

	always_ff @(posedge clock)
	begin
		if (acc_in.valid)
			acc_out.data <= acc_in.data;
	end

endmodule

/* rtl/cic_comb_chain.sv */
module cic_comb_chain
	import cic_pkg::*;
(
	input  logic clock,
	input  logic reset,
	input  logic clear,
	input  acc_sample_t acc_in,
	output acc_sample_t acc_out
);

	// stage_in[i] feeds comb i, the last entry is the chain result
	logic signed [ACC_WIDTH-1:0] stage_in [STAGES+1];
	logic signed [ACC_WIDTH-1:0] delay [STAGES];

	assign stage_in[0] = acc_in.data;

	// ----------------------------------------
	// comb stages, differential delay of 1
	// ----------------------------------------
	for (genvar i = 0; i < STAGES; i++)
	begin : g_stage
		assign stage_in[i+1] = stage_in[i] - delay[i];

		always_ff @(posedge clock)
		begin
			if (reset || clear)
				delay[i] <= '0;
			else if (acc_in.valid)
				delay[i] <= stage_in[i];
		end
	end

	// ----------------------------------------
	// output register
	// ----------------------------------------
	always_ff @(posedge clock)
	begin
		if (reset || clear)
			acc_out.valid <= 1'b0;
		else
			acc_out.valid <= acc_in.valid;
	end

	// whole chain settles within the cycle, only the result is held
	always_ff @(posedge clock)
	begin
		if (acc_in.valid)
			acc_out.data <= stage_in[STAGES];
	end

endmodule

/* rtl/cic_output_round.sv */
module cic_output_round
	import cic_pkg::*;
(
	input  logic clock,
	input  logic reset,
	input  logic clear,
	input  logic [LOG2_WIDTH-1:0] log2_r,
	input  acc_sample_t acc_in,
	output out_sample_t sample_out
);

	int shift;
	logic signed [ACC_WIDTH-1:0] scaled;
	logic [ACC_WIDTH-1:0] below;
	logic round_bit;
	logic signed [OUT_WIDTH:0] rounded;
	logic signed [OUT_WIDTH-1:0] result;

	// ----------------------------------------
	// slice by gain, round half up
	// ----------------------------------------
	always_comb
	begin
		// gain of R^STAGES is a shift of STAGES * log2 R
		shift = STAGES * int'(log2_r);
		scaled = acc_in.data >>> shift;
		below = acc_in.data >> (shift - 1);
		// no fraction below the slice when R is 1
		round_bit = (log2_r != '0) ? below[0] : 1'b0;
		rounded = {scaled[OUT_WIDTH-1], scaled[OUT_WIDTH-1:0]} + {{OUT_WIDTH{1'b0}}, round_bit};

		// rounding only adds, so overflow goes toward the positive limit
		if (rounded[OUT_WIDTH] != rounded[OUT_WIDTH-1])
			result = {1'b0, {(OUT_WIDTH - 1){1'b1}}};
		else
			result = rounded[OUT_WIDTH-1:0];
	end

	// ----------------------------------------
	// output register
	// ----------------------------------------
	always_ff @(posedge clock)
	begin
		if (reset || clear)
			sample_out.valid <= 1'b0;
		else
			sample_out.valid <= acc_in.valid;
	end

	always_ff @(posedge clock)
	begin
		if (acc_in.valid)
			sample_out.data <= result;
	end

endmodule

/* rtl/cic_decimator_top.sv */
module cic_decimator_top
	import cic_pkg::*;
(
	input  logic clock,
	input  logic reset,
	input  apb_req_t apb_req,
	output apb_rsp_t apb_rsp,
	input  in_sample_t sample_in,
	output out_sample_t sample_out
);

	logic enable;
	logic [LOG2_WIDTH-1:0] log2_r;
	logic clear;
	acc_sample_t integ_out;
	acc_sample_t decim_out;
	acc_sample_t comb_out;

	// ----------------------------------------
	// register block
	// ----------------------------------------
	cic_apb_regs i_cic_apb_regs (
		.clock     (clock),
		.reset     (reset),
		.apb_req   (apb_req),
		.apb_rsp   (apb_rsp),
		.out_valid (sample_out.valid),
		.enable    (enable),
		.log2_r    (log2_r),
		.clear     (clear)
	);

	// ----------------------------------------
	// filter pipeline, 4 cycles strobe to strobe
	// ----------------------------------------
	cic_integrator_chain i_cic_integrator_chain (
		.clock     (clock),
		.reset     (reset),
		.clear     (clear),
		.enable    (enable),
		.sample_in (sample_in),
		.acc_out   (integ_out)
	);

	cic_decimation_ctrl i_cic_decimation_ctrl (
		.clock   (clock),
		.reset   (reset),
		.clear   (clear),
		.log2_r  (log2_r),
		.acc_in  (integ_out),
		.acc_out (decim_out)
	);

	cic_comb_chain i_cic_comb_chain (
		.clock   (clock),
		.reset   (reset),
		.clear   (clear),
		.acc_in  (decim_out),
		.acc_out (comb_out)
	);

	cic_output_round i_cic_output_round (
		.clock      (clock),
		.reset      (reset),
		.clear      (clear),
		.log2_r     (log2_r),
		.acc_in     (comb_out),
		.sample_out (sample_out)
	);

endmodule

/* verif/cic_decimator_tb.sv */
module cic_decimator_tb
	import cic_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int MAX_CYCLES = 6000;

	logic clock;
	logic reset;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;
	in_sample_t sample_in;
	out_sample_t sample_out;

	int seed = 43;
	int cycles = 0;
	int value_errors = 0;
	int bus_errors = 0;

	// expectations set by the stimulus
	logic exp_err;
	logic [31:0] exp_rdata;
	logic [31:0] ctrl_word;
	logic signed [IN_WIDTH-1:0] const_in;

	// reference model state
	logic m_enable;
	int m_log2;
	int m_count;
	logic clear_q;
	logic [3:0] exp_pipe;
	int exp_count;
	logic ctrl_accept;

	cic_decimator_top i_cic_decimator_top (
		.clock      (clock),
		.reset      (reset),
		.apb_req    (apb_req),
		.apb_rsp    (apb_rsp),
		.sample_in  (sample_in),
		.sample_out (sample_out)
	);

	initial
	begin
		clock = 1'b0;
		forever
			#10 clock = ~clock;
	end

	always @(posedge clock)
	begin
		cycles++;
		if (cycles >= MAX_CYCLES)
		begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("Test FAILED");
			$finish;
		end
	end

	// ----------------------------------------
	// reference model
	// ----------------------------------------
	assign ctrl_accept = apb_req.psel && apb_req.penable && apb_req.pwrite
		&& apb_req.paddr == CTRL_ADDR && !exp_err;

	always @(posedge clock)
	begin
		if (reset)
		begin
			m_enable <= 1'b0;
			m_log2 <= 0;
			m_count <= 0;
			clear_q <= 1'b0;
			exp_pipe <= '0;
			exp_count <= 0;
		end
		else
		begin
			clear_q <= ctrl_accept;
			if (ctrl_accept)
			begin
				m_enable <= apb_req.pwdata[0];
				m_log2 <= int'(apb_req.pwdata[3:1]);
			end
			// the flush drops history, pending groups and strobes in flight
			if (clear_q)
			begin
				m_count <= 0;
				exp_pipe <= '0;
			end
			else
			begin
				exp_pipe <= {exp_pipe[2:0], 1'b0};
				if (sample_in.valid && m_enable)
				begin
					if (m_count == (1 << m_log2) - 1)
					begin
						m_count <= 0;
						exp_pipe[0] <= 1'b1;
					end
					else
						m_count <= m_count + 1;
				end
			end
			if (ctrl_accept || clear_q)
				exp_count <= 0;
			else if (exp_pipe[3])
				exp_count <= exp_count + 1;
		end
	end

	// ----------------------------------------
	// checks
	// ----------------------------------------
	valid_check: assert property (@(posedge clock) disable iff (reset)
		sample_out.valid == exp_pipe[3])
	else
	begin
		value_errors++;
		$display("FAILED at %0t: sample_out.valid expected %0b, actual %0b",
			$time, $sampled(exp_pipe[3]), $sampled(sample_out.valid));
	end

	// the first outputs still carry the zero history of the combs
	data_check: assert property (@(posedge clock) disable iff (reset)
		(sample_out.valid && exp_count > STAGES) |-> sample_out.data == const_in)
	else
	begin
		value_errors++;
		$display("FAILED at %0t: sample_out.data expected %0d, actual %0d",
			$time, $sampled(const_in), $sampled(sample_out.data));
	end

	bus_check: assert property (@(posedge clock) disable iff (reset)
		(apb_req.psel && apb_req.penable) |-> (apb_rsp.pready && apb_rsp.pslverr == exp_err))
	else
	begin
		bus_errors++;
		$display("FAILED at %0t: apb_rsp.pslverr expected %0b, actual %0b (pready %0b)",
			$time, $sampled(exp_err), $sampled(apb_rsp.pslverr), $sampled(apb_rsp.pready));
	end

	read_check: assert property (@(posedge clock) disable iff (reset)
		(apb_req.psel && apb_req.penable && !apb_req.pwrite && !exp_err)
		|-> apb_rsp.prdata == exp_rdata)
	else
	begin
		value_errors++;
		$display("FAILED at %0t: apb_rsp.prdata expected %0d, actual %0d",
			$time, $sampled(exp_rdata), $sampled(apb_rsp.prdata));
	end

	// ----------------------------------------
	// stimulus tasks
	// ----------------------------------------
	task automatic apb_access(input logic write, input logic [7:0] addr,
		input logic [31:0] data, input logic err, input logic [31:0] expected);
		exp_err = err;
		exp_rdata = expected;
		apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: data};
		@(posedge clock);
		#2;
		apb_req.penable = 1'b1;
		@(posedge clock);
		while (!apb_rsp.pready)
			@(posedge clock);
		#2;
		apb_req = '0;
		exp_err = 1'b0;
	endtask

	task automatic configure(input int log2_r, input logic en);
		ctrl_word = (32'(log2_r) << 1) | 32'(en);
		apb_access(1'b1, CTRL_ADDR, ctrl_word, 1'b0, '0);
		apb_access(1'b0, COUNT_ADDR, '0, 1'b0, 32'd0);
	endtask

	// strobes arrive with random gaps
	task automatic drive_samples(input int count);
		int sent;
		sent = 0;
		while (sent < count)
		begin
			@(posedge clock);
			#2;
			sample_in.data = const_in;
			sample_in.valid = ({$random(seed)} % 4) != 0;
			if (sample_in.valid)
				sent++;
		end
		@(posedge clock);
		#2;
		sample_in.valid = 1'b0;
	endtask

	task automatic idle_cycles(input int count);
		repeat (count) @(posedge clock);
		#2;
	endtask

	// ----------------------------------------
	// test sequence
	// ----------------------------------------
	initial
	begin
		int r;
		int n;
		logic signed [IN_WIDTH-1:0] levels [3];
		reset = 1'b1;
		apb_req = '0;
		sample_in = '0;
		exp_err = 1'b0;
		exp_rdata = '0;
		ctrl_word = '0;
		const_in = '0;
		repeat (8) @(posedge clock);
		#2;
		reset = 1'b0;

		// disabled after reset
		const_in = 16'sd1234;
		drive_samples(40);
		idle_cycles(8);
		apb_access(1'b0, COUNT_ADDR, '0, 1'b0, 32'd0);

		// constant input at every decimation factor
		for (int k = 0; k <= MAX_LOG2; k++)
		begin
			r = 1 << k;
			levels[0] = 16'($random(seed));
			levels[1] = 16'sh7fff;
			levels[2] = 16'sh8000;
			for (int v = 0; v < 3; v++)
			begin
				const_in = levels[v];
				configure(k, 1'b1);
				n = 8 * r + r / 2;
				drive_samples(n);
				idle_cycles(8);
				apb_access(1'b0, COUNT_ADDR, '0, 1'b0, 32'(n / r));
				apb_access(1'b0, CTRL_ADDR, '0, 1'b0, ctrl_word);
			end
		end

		// rejected writes leave the control word alone
		apb_access(1'b1, CTRL_ADDR, 32'h0000_000d, 1'b1, '0);
		apb_access(1'b1, COUNT_ADDR, 32'h0000_0003, 1'b1, '0);
		apb_access(1'b0, CTRL_ADDR, '0, 1'b0, ctrl_word);

		// write in the middle of a group restarts grouping
		configure(3, 1'b1);
		drive_samples(8 * 6 + 3);
		idle_cycles(8);
		configure(3, 1'b1);
		drive_samples(8);
		idle_cycles(8);
		apb_access(1'b0, COUNT_ADDR, '0, 1'b0, 32'd1);

		configure(3, 1'b0);
		drive_samples(24);
		idle_cycles(8);
		apb_access(1'b0, COUNT_ADDR, '0, 1'b0, 32'd0);

		$display("errors: %0d value, %0d bus", value_errors, bus_errors);
		if (value_errors == 0 && bus_errors == 0)
		begin
			$display("Test OK");
		end
		else
		begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

/* tb.f */
rtl/cic_pkg.sv
rtl/cic_apb_regs.sv
rtl/cic_integrator_chain.sv
rtl/cic_decimation_ctrl.sv
rtl/cic_comb_chain.sv
rtl/cic_output_round.sv
rtl/cic_decimator_top.sv
verif/cic_decimator_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the CIC decimator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f \
	--top-module cic_decimator_tb -o cic_sim
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit 1
fi

output=$(./obj_dir/cic_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test OK"; then
	exit 0
fi
exit 1
